// ==== design/fDivPkg.sv ====
`include "fDiv_settings.svh"

package fDivPkg;

    typedef logic [31:0] FpWord;
    typedef logic [`FDIV_SQN_W-1:0] SqN;
    typedef logic [`FDIV_TAG_W-1:0] Tag;
    typedef logic [`FDIV_REG_W-1:0] RegNm;
    typedef logic [2:0] RoundMode;
    typedef logic [23:0] Mant;
    typedef logic signed [9:0] Exp;

    localparam RoundMode RM_RNE = 3'd0;
    localparam RoundMode RM_RTZ = 3'd1;
    localparam RoundMode RM_RDN = 3'd2;
    localparam RoundMode RM_RUP = 3'd3;
    localparam RoundMode RM_RMM = 3'd4;

    localparam FpWord CANON_NAN = 32'h7fc00000;

    // IEEE flag bits in the order NV, DZ, OF, UF, NX.
    localparam logic [4:0] RAW_NV = 5'b10000;
    localparam logic [4:0] RAW_DZ = 5'b01000;
    localparam logic [4:0] RAW_OF = 5'b00100;
    localparam logic [4:0] RAW_UF = 5'b00010;
    localparam logic [4:0] RAW_NX = 5'b00001;

    typedef struct packed {
        FpWord srcA;
        FpWord srcB;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
        logic [31:0] pc;
        logic valid;
    } ExUOp;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchProv;

    typedef enum logic [2:0] {
        FLAGS_NONE,
        FLAGS_FP_NX,
        FLAGS_FP_UF,
        FLAGS_FP_OF,
        FLAGS_FP_DZ,
        FLAGS_FP_NV,
        FLAGS_ILLEGAL_INSTR
    } Flags;

    typedef struct packed {
        FpWord result;
        Tag tagDst;
        RegNm nmDst;
        SqN sqN;
        logic [31:0] pc;
        Flags flags;
        logic valid;
    } ResUOp;

    typedef struct packed {
        logic sign;
        Exp exp;
        Mant mant;
        logic isZero;
        logic isInf;
        logic isNan;
    } UnpackedOp;

    typedef struct packed {
        logic hit;
        FpWord value;
        logic [4:0] rawFlags;
    } SpecialRes;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } DivState;

endpackage

// ==== design/fDivUnit.sv ====
`timescale 1ns/1ps
`include "fDiv_settings.svh"

module fDivUnit import fDivPkg::*; (
    input logic clk,
    input logic rst,
    input logic en,
    input logic wbAvail,
    output logic busy,
    input BranchProv branch,
    input ExUOp uop,
    input RoundMode fRoundMode,
    output ResUOp resUop
);

    function automatic logic isFlushed(SqN sqN, BranchProv br);
        return br.taken && ($signed(sqN - br.sqN) > 0);
    endfunction

    // Underflow wins over overflow, then DZ, NV and NX.
    function automatic Flags collapseFlags(logic [4:0] raw, RoundMode rm);
        Flags f;
        if (|(raw & RAW_UF)) begin
            f = FLAGS_FP_UF;
        end else if (|(raw & RAW_OF)) begin
            f = FLAGS_FP_OF;
        end else if (|(raw & RAW_DZ)) begin
            f = FLAGS_FP_DZ;
        end else if (|(raw & RAW_NV)) begin
            f = FLAGS_FP_NV;
        end else if (|(raw & RAW_NX)) begin
            f = FLAGS_FP_NX;
        end else begin
            f = FLAGS_NONE;
        end
        if (rm > RM_RMM) begin
            f = FLAGS_ILLEGAL_INSTR;
        end
        return f;
    endfunction

    logic running;
    logic startDiv;
    logic outValid;
    logic accept;
    logic outFlush;
    logic finish;
    logic divKill;

    UnpackedOp unpA;
    UnpackedOp unpB;
    SpecialRes unpSpecial;
    UnpackedOp opA;
    UnpackedOp opB;
    SpecialRes special;
    RoundMode rmQ;

    Tag tagQ;
    RegNm nmQ;
    SqN sqNQ;
    logic [31:0] pcQ;
    FpWord resultQ;
    Flags flagsQ;

    logic divDone;
    logic [`FDIV_ITERS-1:0] quotient;
    logic sticky;
    Exp expDiff;
    FpWord packRes;
    logic [4:0] packFlags;
    logic [4:0] rawFlags;

    // ********************
    // Issue and flush
    // ********************

    assign accept = en && uop.valid && !running && !outValid
                    && !isFlushed(uop.sqN, branch);
    assign outFlush = isFlushed(sqNQ, branch);
    assign finish = running && divDone && !outFlush;
    assign divKill = running && outFlush;
    assign busy = running || (en && uop.valid) || outValid;

    fpUnpack fpUnpack_i (
        .a(uop.srcA),
        .b(uop.srcB),
        .opA(unpA),
        .opB(unpB),
        .special(unpSpecial)
    );

    mantDivider mantDivider_i (
        .clk(clk),
        .rst(rst),
        .start(startDiv),
        .kill(divKill),
        .dividend(opA.mant),
        .divisor(opB.mant),
        .done(divDone),
        .quotient(quotient),
        .sticky(sticky)
    );

    assign expDiff = $signed(opA.exp) - $signed(opB.exp) + Exp'(127);

    fpRoundPack fpRoundPack_i (
        .sign(opA.sign ^ opB.sign),
        .expDiff(expDiff),
        .quotient(quotient),
        .sticky(sticky),
        .mode(rmQ),
        .result(packRes),
        .rawFlags(packFlags)
    );

    assign rawFlags = special.hit ? special.rawFlags : packFlags;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            startDiv <= 1'b0;
            outValid <= 1'b0;
        end else begin
            startDiv <= accept;
            if (accept) begin
                running <= 1'b1;
            end else if (finish) begin
                running <= 1'b0;
                outValid <= 1'b1;
            end else begin
                if (outFlush || wbAvail) begin
                    outValid <= 1'b0;
                end
                if (outFlush) begin
                    running <= 1'b0;
                end
            end
        end
    end

    // ********************
    // Result micro-op
    // ********************

    always_ff @(posedge clk) begin
        if (accept) begin
            tagQ <= uop.tagDst;
            nmQ <= uop.nmDst;
            sqNQ <= uop.sqN;
            pcQ <= uop.pc;
            rmQ <= fRoundMode;
            opA <= unpA;
            opB <= unpB;
            special <= unpSpecial;
        end
        if (finish) begin
            resultQ <= special.hit ? special.value : packRes;
            flagsQ <= collapseFlags(rawFlags, rmQ);
        end
    end

    always_comb begin
        resUop.result = resultQ;
        resUop.tagDst = tagQ;
        resUop.nmDst = nmQ;
        resUop.sqN = sqNQ;
        resUop.pc = pcQ;
        resUop.flags = flagsQ;
        resUop.valid = outValid;
    end

    // Results only come out of a divide that was running.
    assert property (@(posedge clk) disable iff (rst) $rose(outValid) |-> $past(running))
        else $error("fDivUnit result valid without a running divide");

    assert property (@(posedge clk) disable iff (rst) outValid |-> busy)
        else $error("fDivUnit not busy while holding a result");

endmodule

// ==== design/fDiv_settings.svh ====
`ifndef FDIV_SETTINGS_SVH
`define FDIV_SETTINGS_SVH

// Sequence number width, compared with wraparound.
`define FDIV_SQN_W 7

// Physical destination tag width.
`define FDIV_TAG_W 7

// Architectural destination register width.
`define FDIV_REG_W 5

// Quotient bits per divide.
// 24 mantissa bits plus guard, round and one bit for normalization.
`define FDIV_ITERS 27

`endif

// ==== design/fpRoundPack.sv ====
`timescale 1ns/1ps
`include "fDiv_settings.svh"

module fpRoundPack import fDivPkg::*; (
    input logic sign,
    input Exp expDiff,
    input logic [`FDIV_ITERS-1:0] quotient,
    input logic sticky,
    input RoundMode mode,
    output FpWord result,
    output logic [4:0] rawFlags
);

    logic [`FDIV_ITERS-1:0] normQ;
    Exp normExp;
    Mant mant;
    logic guardBit;
    logic roundBit;
    logic stickyBit;
    logic inexact;
    logic roundUp;
    logic toInf;
    logic [24:0] mantInc;
    Exp roundExp;

    // Quotient lies in (0.5, 2), so at most one shift is needed.
    assign normQ = quotient[`FDIV_ITERS-1] ? quotient
                                           : {quotient[`FDIV_ITERS-2:0], 1'b0};
    assign normExp = quotient[`FDIV_ITERS-1] ? expDiff : expDiff - Exp'(1);

    assign mant = normQ[`FDIV_ITERS-1:`FDIV_ITERS-24];
    assign guardBit = normQ[2];
    assign roundBit = normQ[1];
    assign stickyBit = normQ[0] || sticky;
    assign inexact = guardBit || roundBit || stickyBit;

    always_comb begin
        case (mode)
            RM_RNE: roundUp = guardBit && (roundBit || stickyBit || mant[0]);
            RM_RTZ: roundUp = 1'b0;
            RM_RDN: roundUp = inexact && sign;
            RM_RUP: roundUp = inexact && !sign;
            RM_RMM: roundUp = guardBit;
            default: roundUp = guardBit && (roundBit || stickyBit || mant[0]);
        endcase
    end

    // Direction of an overflowed result.
    always_comb begin
        case (mode)
            RM_RTZ: toInf = 1'b0;
            RM_RDN: toInf = sign;
            RM_RUP: toInf = !sign;
            default: toInf = 1'b1;
        endcase
    end

    // A carry out of the mantissa leaves 1.0 and bumps the exponent.
    assign mantInc = {1'b0, mant} + {24'd0, roundUp};
    assign roundExp = normExp + Exp'({9'd0, mantInc[24]});

    always_comb begin
        result = {sign, roundExp[7:0], mantInc[22:0]};
        rawFlags = inexact ? RAW_NX : 5'b00000;
        if (roundExp >= Exp'(255)) begin
            result = toInf ? {sign, 8'hff, 23'd0} : {sign, 8'hfe, 23'h7fffff};
            rawFlags = RAW_OF | RAW_NX;
        end else if (roundExp <= Exp'(0)) begin
            // Too small for a normal, flushed to zero.
            result = {sign, 31'd0};
            rawFlags = RAW_UF | RAW_NX;
        end
    end

endmodule

// ==== design/fpUnpack.sv ====
`timescale 1ns/1ps

module fpUnpack import fDivPkg::*; (
    input FpWord a,
    input FpWord b,
    output UnpackedOp opA,
    output UnpackedOp opB,
    output SpecialRes special
);

    function automatic UnpackedOp classify(FpWord w);
        UnpackedOp u;
        logic expZero;
        logic expMax;
        logic fracZero;
        expZero = (w[30:23] == 8'd0);
        expMax = (w[30:23] == 8'hff);
        fracZero = (w[22:0] == 23'd0);
        u.sign = w[31];
        u.exp = Exp'({2'b00, w[30:23]});
        // Subnormals read as zero.
        u.mant = expZero ? Mant'(0) : {1'b1, w[22:0]};
        u.isZero = expZero;
        u.isInf = expMax && fracZero;
        u.isNan = expMax && !fracZero;
        return u;
    endfunction

    logic qSign;

    assign opA = classify(a);
    assign opB = classify(b);
    assign qSign = a[31] ^ b[31];

    always_comb begin
        special.hit = 1'b1;
        special.value = {qSign, 31'd0};
        special.rawFlags = 5'b00000;
        if (opA.isNan || opB.isNan || (opA.isZero && opB.isZero)
            || (opA.isInf && opB.isInf)) begin
            special.value = CANON_NAN;
            special.rawFlags = RAW_NV;
        end else if (opA.isInf) begin
            special.value = {qSign, 8'hff, 23'd0};
        end else if (opB.isZero) begin
            special.value = {qSign, 8'hff, 23'd0};
            special.rawFlags = RAW_DZ;
        end else if (opA.isZero || opB.isInf) begin
            special.value = {qSign, 31'd0};
        end else begin
            // Both finite and nonzero, the divider result is used.
            special.hit = 1'b0;
        end
    end

endmodule

// ==== design/mantDivider.sv ====
`timescale 1ns/1ps
`include "fDiv_settings.svh"

module mantDivider import fDivPkg::*; (
    input logic clk,
    input logic rst,
    input logic start,
    input logic kill,
    input Mant dividend,
    input Mant divisor,
    output logic done,
    output logic [`FDIV_ITERS-1:0] quotient,
    output logic sticky
);

    localparam int CNT_W = $clog2(`FDIV_ITERS);

    DivState state;
    logic [CNT_W-1:0] stepCnt;
    logic [25:0] rem;
    Mant divReg;

    logic [25:0] curRem;
    logic [25:0] curDiv;
    logic [25:0] diff;
    logic qBit;
    logic [25:0] nextRem;

    // ********************
    // One restoring step
    // ********************

    // The first step runs on the start edge straight from the inputs.
    assign curRem = (state == IDLE) ? {2'b00, dividend} : rem;
    assign curDiv = (state == IDLE) ? {2'b00, divisor} : {2'b00, divReg};
    assign diff = curRem - curDiv;
    assign qBit = (curRem >= curDiv);
    assign nextRem = qBit ? {diff[24:0], 1'b0} : {curRem[24:0], 1'b0};

    always_ff @(posedge clk) begin
        if (rst || kill) begin
            state <= IDLE;
            stepCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    stepCnt <= CNT_W'(1);
                    if (start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    stepCnt <= stepCnt + CNT_W'(1);
                    if (stepCnt == CNT_W'(`FDIV_ITERS - 1)) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE && start) || state == RUN) begin
            rem <= nextRem;
            quotient <= {quotient[`FDIV_ITERS-2:0], qBit};
        end
        if (state == IDLE) begin
            divReg <= divisor;
        end
    end

    assign done = (state == DONE);
    assign sticky = |rem;

    // The unit must not restart the divider while a divide is in flight.
    assert property (@(posedge clk) disable iff (rst) start |-> state == IDLE)
        else $error("mantDivider start outside IDLE");

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the fDivUnit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fDivTb \
    -Mdir obj_dir -f sim.f || { echo "build failed"; exit 1; }

out="$(./obj_dir/VfDivTb 2>&1)"
echo "$out"

echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

// ==== sim.f ====
+incdir+design
design/fDivPkg.sv
design/fpUnpack.sv
design/mantDivider.sv
design/fpRoundPack.sv
design/fDivUnit.sv
tests/fDivTb.sv

// ==== tests/fDivTb.sv ====
`timescale 1ns/1ps
`include "fDiv_settings.svh"

module fDivTb import fDivPkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RESULT_TIMEOUT = `FDIV_ITERS + 20;

    logic clk;
    logic rst;
    logic en;
    logic wbAvail;
    logic busy;
    BranchProv branch;
    ExUOp uop;
    RoundMode fRoundMode;
    ResUOp resUop;

    FpWord expResult;
    Flags expFlags;
    Tag expTag;
    SqN expSqN;
    Tag nextTag;
    logic killed;
    logic flushNow;
    logic acceptNow;
    int sinceAccept;
    integer seed;
    int mismatches;
    int failures;

    fDivUnit fDivUnit_i (
        .clk(clk),
        .rst(rst),
        .en(en),
        .wbAvail(wbAvail),
        .busy(busy),
        .branch(branch),
        .uop(uop),
        .fRoundMode(fRoundMode),
        .resUop(resUop)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Counts edges since the one at which the DUT should take a micro-op.
    always @(posedge clk) begin
        if (acceptNow) begin
            sinceAccept <= 0;
        end else begin
            sinceAccept <= sinceAccept + 1;
        end
    end

    // ********************
    // Reference model
    // ********************

    // Widens a normal binary32 value into a binary64 real.
    function automatic real toReal(FpWord w);
        logic [10:0] e;
        e = {3'b000, w[30:23]} + 11'd896;
        return $bitstoreal({w[31], e, w[22:0], 29'd0});
    endfunction

    // Binary64 has enough bits that rounding twice gives the correctly rounded quotient.
    function automatic FpWord toSingleRne(real r);
        logic [63:0] d;
        logic [10:0] e;
        logic [24:0] m;
        logic up;
        d = $realtobits(r);
        e = d[62:52] - 11'd896;
        m = {2'b01, d[51:29]};
        up = d[28] && ((|d[27:0]) || d[29]);
        m = m + {24'd0, up};
        if (m[24]) begin
            e = e + 11'd1;
        end
        return {d[63], e[7:0], m[22:0]};
    endfunction

    // Program counter that each issued micro-op carries.
    function automatic logic [31:0] pcFor(Tag t);
        return 32'h0000_1000 + {23'd0, t, 2'b00};
    endfunction

    // ********************
    // Checks
    // ********************

    resultCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.result == expResult)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.result expected %h actual %h",
                     $time, $sampled(expResult), $sampled(resUop.result));
        end

    flagsCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.flags == expFlags)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.flags expected %0d actual %0d",
                     $time, $sampled(expFlags), $sampled(resUop.flags));
        end

    tagCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.tagDst == expTag)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.tagDst expected %0d actual %0d",
                     $time, $sampled(expTag), $sampled(resUop.tagDst));
        end

    nmCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.nmDst == RegNm'(expTag))
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.nmDst expected %0d actual %0d",
                     $time, RegNm'($sampled(expTag)), $sampled(resUop.nmDst));
        end

    sqNCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.sqN == expSqN)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.sqN expected %0d actual %0d",
                     $time, $sampled(expSqN), $sampled(resUop.sqN));
        end

    pcCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !killed) |-> resUop.pc == pcFor(expTag))
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.pc expected %h actual %h",
                     $time, pcFor($sampled(expTag)), $sampled(resUop.pc));
        end

    // Results rise a fixed number of cycles after the accept cycle.
    latencyCheck: assert property (@(posedge clk) disable iff (rst)
        $rose(resUop.valid) |-> sinceAccept + 1 == `FDIV_ITERS + 2)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.valid latency expected %0d actual %0d",
                     $time, `FDIV_ITERS + 2, $sampled(sinceAccept) + 1);
        end

    busyCheck: assert property (@(posedge clk) disable iff (rst) resUop.valid |-> busy)
        else begin
            mismatches++;
            $display("mismatch at %0t: busy expected 1 actual %b", $time, $sampled(busy));
        end

    // A stalled result holds still until writeback takes it.
    holdCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && !wbAvail && !branch.taken) |=>
            (resUop.valid && busy && $stable(resUop.result) && $stable(resUop.flags)
             && $stable(resUop.tagDst)))
        else begin
            failures++;
            $display("result changed or dropped while writeback was stalled at %0t", $time);
        end

    retireCheck: assert property (@(posedge clk) disable iff (rst)
        (resUop.valid && wbAvail && !branch.taken) |=> !resUop.valid)
        else begin
            mismatches++;
            $display("mismatch at %0t: resUop.valid expected 0 actual %b",
                     $time, $sampled(resUop.valid));
        end

    flushCheck: assert property (@(posedge clk) disable iff (rst)
        flushNow |=> (!busy && !resUop.valid))
        else begin
            failures++;
            $display("unit still busy or valid after a flush at %0t", $time);
        end

    killedCheck: assert property (@(posedge clk) disable iff (rst) resUop.valid |-> !killed)
        else begin
            failures++;
            $display("a flushed micro-op produced a result at %0t", $time);
        end

    // ********************
    // Stimulus
    // ********************

    task automatic printCounts();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic issueOp(FpWord a, FpWord b, RoundMode rm, SqN sq);
        uop.srcA = a;
        uop.srcB = b;
        uop.tagDst = nextTag;
        uop.nmDst = RegNm'(nextTag);
        uop.sqN = sq;
        uop.pc = pcFor(nextTag);
        uop.valid = 1'b1;
        en = 1'b1;
        fRoundMode = rm;
        expSqN = sq;
        acceptNow = 1'b1;
        nextTag = nextTag + Tag'(1);
        tick();
        uop.valid = 1'b0;
        en = 1'b0;
        acceptNow = 1'b0;
    endtask

    task automatic awaitResult();
        int waited;
        waited = 0;
        while (!resUop.valid && waited < RESULT_TIMEOUT) begin
            tick();
            waited++;
        end
        if (!resUop.valid) begin
            failures++;
            $display("timeout: no valid result after %0d cycles at %0t", waited, $time);
            printCounts();
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic retireResult();
        wbAvail = 1'b1;
        tick();
        wbAvail = 1'b0;
    endtask

    task automatic checkedDivide(FpWord a, FpWord b, RoundMode rm, FpWord res, Flags f);
        expResult = res;
        expFlags = f;
        expTag = nextTag;
        issueOp(a, b, rm, SqN'(10));
        awaitResult();
        retireResult();
    endtask

    task automatic pulseBranch(SqN sq, logic flushes);
        branch.taken = 1'b1;
        branch.sqN = sq;
        flushNow = flushes;
        tick();
        branch.taken = 1'b0;
        flushNow = 1'b0;
        killed = flushes;
    endtask

    task automatic roundingCases();
        for (int m = 0; m < 5; m++) begin
            checkedDivide(32'h40c00000, 32'h40400000, RoundMode'(m), 32'h40000000, FLAGS_NONE);
            checkedDivide(32'hbf800000, 32'h40800000, RoundMode'(m), 32'hbe800000, FLAGS_NONE);
        end
        checkedDivide(32'h3f800000, 32'h40400000, RM_RNE, 32'h3eaaaaab, FLAGS_FP_NX);
        checkedDivide(32'h3f800000, 32'h40400000, RM_RTZ, 32'h3eaaaaaa, FLAGS_FP_NX);
        checkedDivide(32'h3f800000, 32'h40400000, RM_RDN, 32'h3eaaaaaa, FLAGS_FP_NX);
        checkedDivide(32'h3f800000, 32'h40400000, RM_RUP, 32'h3eaaaaab, FLAGS_FP_NX);
        checkedDivide(32'h3f800000, 32'h40400000, RM_RMM, 32'h3eaaaaab, FLAGS_FP_NX);
        checkedDivide(32'hbf800000, 32'h40400000, RM_RDN, 32'hbeaaaaab, FLAGS_FP_NX);
        checkedDivide(32'hbf800000, 32'h40400000, RM_RUP, 32'hbeaaaaaa, FLAGS_FP_NX);
    endtask

    task automatic specialCases();
        checkedDivide(32'h3f800000, 32'h00000000, RM_RNE, 32'h7f800000, FLAGS_FP_DZ);
        checkedDivide(32'hbf800000, 32'h00000000, RM_RNE, 32'hff800000, FLAGS_FP_DZ);
        checkedDivide(32'h00000000, 32'h00000000, RM_RNE, 32'h7fc00000, FLAGS_FP_NV);
        checkedDivide(32'h7f800000, 32'h7f800000, RM_RNE, 32'h7fc00000, FLAGS_FP_NV);
        checkedDivide(32'h7f800001, 32'h3f800000, RM_RNE, 32'h7fc00000, FLAGS_FP_NV);
        checkedDivide(32'h7f800000, 32'h40400000, RM_RNE, 32'h7f800000, FLAGS_NONE);
        checkedDivide(32'h00000000, 32'h40400000, RM_RNE, 32'h00000000, FLAGS_NONE);
        checkedDivide(32'h7f000000, 32'h00800000, RM_RNE, 32'h7f800000, FLAGS_FP_OF);
        checkedDivide(32'h7f000000, 32'h00800000, RM_RTZ, 32'h7f7fffff, FLAGS_FP_OF);
        checkedDivide(32'h00800000, 32'h7f000000, RM_RNE, 32'h00000000, FLAGS_FP_UF);
    endtask

    task automatic illegalModes();
        for (int m = 5; m < 8; m++) begin
            checkedDivide(32'h40c00000, 32'h40400000, RoundMode'(m), 32'h40000000,
                          FLAGS_ILLEGAL_INSTR);
        end
    endtask

    // Exponents stay near the bias so every quotient is normal.
    task automatic randomDivides(int count);
        FpWord a;
        FpWord b;
        FpWord q;
        Flags f;
        for (int i = 0; i < count; i++) begin
            a = {1'($random(seed)), 8'(100 + {$random(seed)} % 55), 23'($random(seed))};
            b = {1'($random(seed)), 8'(100 + {$random(seed)} % 55), 23'($random(seed))};
            q = toSingleRne(toReal(a) / toReal(b));
            f = (toReal(q) * toReal(b) == toReal(a)) ? FLAGS_NONE : FLAGS_FP_NX;
            checkedDivide(a, b, RM_RNE, q, f);
        end
    endtask

    task automatic flushInFlight();
        expTag = nextTag;
        issueOp(32'h40c00000, 32'h40400000, RM_RNE, SqN'(10));
        repeat (5) tick();
        pulseBranch(SqN'(3), 1'b1);
        repeat (`FDIV_ITERS + 10) tick();
        killed = 1'b0;
    endtask

    task automatic flushWhileHolding();
        expResult = 32'h40000000;
        expFlags = FLAGS_NONE;
        expTag = nextTag;
        issueOp(32'h40c00000, 32'h40400000, RM_RNE, SqN'(10));
        awaitResult();
        repeat (3) tick();
        pulseBranch(SqN'(3), 1'b1);
        repeat (4) tick();
        killed = 1'b0;
    endtask

    task automatic youngerBranchKeeps();
        expResult = 32'hbe800000;
        expFlags = FLAGS_NONE;
        expTag = nextTag;
        issueOp(32'hbf800000, 32'h40800000, RM_RNE, SqN'(10));
        repeat (5) tick();
        pulseBranch(SqN'(20), 1'b0);
        awaitResult();
        retireResult();
    endtask

    task automatic backPressure();
        Tag secondTag;
        expResult = 32'h40000000;
        expFlags = FLAGS_NONE;
        expTag = nextTag;
        issueOp(32'h40c00000, 32'h40400000, RM_RNE, SqN'(10));
        awaitResult();
        // Second micro-op waits at issue while the first result is stalled.
        secondTag = nextTag;
        uop.srcA = 32'hbf800000;
        uop.srcB = 32'h40800000;
        uop.tagDst = secondTag;
        uop.nmDst = RegNm'(secondTag);
        uop.sqN = SqN'(11);
        uop.pc = pcFor(secondTag);
        uop.valid = 1'b1;
        en = 1'b1;
        nextTag = nextTag + Tag'(1);
        repeat (10) tick();
        retireResult();
        expResult = 32'hbe800000;
        expTag = secondTag;
        expSqN = SqN'(11);
        acceptNow = 1'b1;
        tick();
        uop.valid = 1'b0;
        en = 1'b0;
        acceptNow = 1'b0;
        awaitResult();
        retireResult();
    endtask

    task automatic reportAndFinish();
        printCounts();
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        seed = 32'ha67b;
        mismatches = 0;
        failures = 0;
        rst = 1'b1;
        en = 1'b0;
        wbAvail = 1'b0;
        branch = '0;
        uop = '0;
        fRoundMode = RM_RNE;
        expResult = '0;
        expFlags = FLAGS_NONE;
        expTag = '0;
        expSqN = '0;
        nextTag = Tag'(1);
        killed = 1'b0;
        flushNow = 1'b0;
        acceptNow = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        roundingCases();
        specialCases();
        illegalModes();
        randomDivides(40);
        flushInFlight();
        flushWhileHolding();
        youngerBranchKeeps();
        backPressure();
        repeat (3) tick();
        reportAndFinish();
    end

endmodule
